//--- core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Completion end sizing
////////////////////////////////////////////////////////////////////////////

// Reorder buffer entries and the starting credit count of the dispatcher
`define CORE_ROB_DEPTH 16

// Store buffer entries
`define CORE_SB_DEPTH 8

// Dispatch lanes and retire lanes per cycle
`define CORE_WIDTH 2

// Data and address width
`define CORE_XLEN 32

`endif

//--- core_pkg.sv
`include "core_config.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]               word_t;       // Data or address
    typedef logic [4:0]                          reg_idx_t;    // Architectural rd
    typedef logic [$clog2(`CORE_ROB_DEPTH)-1:0]  rob_idx_t;    // ROB slot number
    typedef logic [$clog2(`CORE_SB_DEPTH)-1:0]   sb_idx_t;     // Store buffer slot number
    typedef logic [1:0]                          credit_cnt_t; // 0 to 2 per cycle

    typedef struct packed {
        logic     valid;
        logic     is_store;
        reg_idx_t rd;
    } dispatch_t;

    // Result from an execution unit with addr used only by stores
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        word_t    data;     // Result or store data
        word_t    addr;     // Store address
    } complete_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } retire_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    typedef struct packed {
        logic   valid;
        store_t st;
    } sb_push_t;    // One retiring store on its way into the store buffer

    typedef enum logic [1:0] {
        IDLE,   // Nothing outstanding at the cache
        SEND,   // Request on st_req this cycle
        WAIT    // Waiting for store_finish
    } drain_state_t;

endpackage

//--- core_retire_top.sv
`timescale 1ns/10ps
`include "core_config.svh"

module core_retire_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  core_pkg::dispatch_t [`CORE_WIDTH-1:0] disp,
    input  core_pkg::complete_t                   cmp_a,
    input  core_pkg::complete_t                   cmp_b,
    input  logic                                  store_finish,
    input  core_pkg::word_t                       store_fin_addr,
    output core_pkg::retire_t   [`CORE_WIDTH-1:0] ret,
    output core_pkg::credit_cnt_t                 credit_ret,
    output logic                                  st_req_valid,
    output core_pkg::store_t                      st_req
);

    core_pkg::rob_idx_t                     head, tail;
    core_pkg::credit_cnt_t                  disp_cnt, ret_cnt, sb_free_cnt;
    core_pkg::sb_push_t [`CORE_WIDTH-1:0]   sb_push;    // Retiring stores
    core_pkg::store_t                       drain_store;
    logic                                   drain_avail, drain_pick;

    // Lane 1 is only valid with lane 0
    assign disp_cnt = {1'b0, disp[0].valid} + {1'b0, disp[1].valid};

    ////////////////////////////////////////////////////////////////////////////
    // Reorder buffer
    ////////////////////////////////////////////////////////////////////////////

    rob_pointers u_rob_pointers (
        .clk        (clk),
        .rst_n      (rst_n),
        .disp_cnt   (disp_cnt),
        .ret_cnt    (ret_cnt),
        .head       (head),
        .tail       (tail),
        .credit_ret (credit_ret)
    );

    rob_entries u_rob_entries (
        .clk         (clk),
        .rst_n       (rst_n),
        .disp        (disp),
        .tail        (tail),
        .head        (head),
        .cmp_a       (cmp_a),
        .cmp_b       (cmp_b),
        .sb_free_cnt (sb_free_cnt),
        .ret         (ret),
        .ret_cnt     (ret_cnt),
        .sb_push     (sb_push)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Store side
    ////////////////////////////////////////////////////////////////////////////

    store_buffer u_store_buffer (
        .clk            (clk),
        .rst_n          (rst_n),
        .sb_push        (sb_push),
        .sb_free_cnt    (sb_free_cnt),
        .drain_pick     (drain_pick),
        .drain_store    (drain_store),
        .drain_avail    (drain_avail),
        .store_finish   (store_finish),
        .store_fin_addr (store_fin_addr)
    );

    store_drain_fsm u_store_drain_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .drain_avail  (drain_avail),
        .drain_store  (drain_store),
        .store_finish (store_finish),
        .drain_pick   (drain_pick),
        .st_req_valid (st_req_valid),
        .st_req       (st_req)
    );

endmodule

//--- rob_entries.sv
`timescale 1ns/10ps
`include "core_config.svh"

module rob_entries (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  core_pkg::dispatch_t [`CORE_WIDTH-1:0]     disp,
    input  core_pkg::rob_idx_t                        tail,
    input  core_pkg::rob_idx_t                        head,
    input  core_pkg::complete_t                       cmp_a,        // Execution unit A
    input  core_pkg::complete_t                       cmp_b,        // Execution unit B
    input  core_pkg::credit_cnt_t                     sb_free_cnt,  // Free store slots, capped at 2
    output core_pkg::retire_t   [`CORE_WIDTH-1:0]     ret,
    output core_pkg::credit_cnt_t                     ret_cnt,
    output core_pkg::sb_push_t  [`CORE_WIDTH-1:0]     sb_push
);

    localparam int DEPTH = `CORE_ROB_DEPTH;

    // Control bits per entry
    logic [DEPTH-1:0] busy;         // Allocated and not yet retired
    logic [DEPTH-1:0] finished;     // Result written back

    // Payload per entry
    logic                 is_store_q [DEPTH];
    core_pkg::reg_idx_t   rd_q       [DEPTH];
    core_pkg::word_t      data_q     [DEPTH];
    core_pkg::word_t      addr_q     [DEPTH];

    core_pkg::rob_idx_t                   head_nxt;
    core_pkg::rob_idx_t [`CORE_WIDTH-1:0] disp_idx;    // Slot for each dispatch lane
    logic                                 rdy0, rdy1;
    logic [`CORE_WIDTH-1:0]               ret_go;      // Lane retires this cycle

    assign head_nxt = head + core_pkg::rob_idx_t'(1);

    always_comb begin
        for (int l = 0; l < `CORE_WIDTH; l++) begin
            disp_idx[l] = tail + core_pkg::rob_idx_t'(l);   // Lane 0 at tail and lane 1 next
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // In-order retire decision
    ////////////////////////////////////////////////////////////////////////////

    assign rdy0 = busy[head] & finished[head];
    assign rdy1 = busy[head_nxt] & finished[head_nxt];

    // A store needs its own free slot and two stores need two
    assign ret_go[0] = rdy0 & (~is_store_q[head] | (sb_free_cnt != 2'd0));
    assign ret_go[1] = ret_go[0] & rdy1
                     & (~is_store_q[head_nxt]
                        | (sb_free_cnt >= (is_store_q[head] ? 2'd2 : 2'd1)));

    assign ret_cnt = ret_go[1] ? 2'd2 : (ret_go[0] ? 2'd1 : 2'd0);

    // Stores leave towards the store buffer in lane order
    assign sb_push[0].valid   = ret_go[0] & is_store_q[head];
    assign sb_push[0].st.addr = addr_q[head];
    assign sb_push[0].st.data = data_q[head];
    assign sb_push[1].valid   = ret_go[1] & is_store_q[head_nxt];
    assign sb_push[1].st.addr = addr_q[head_nxt];
    assign sb_push[1].st.data = data_q[head_nxt];

    ////////////////////////////////////////////////////////////////////////////
    // Entry state and retire outputs
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= '0;
            finished <= '0;
            ret      <= '0;
        end else begin
            if (ret_go[0]) begin            // Free retired slots
                busy[head]     <= 1'b0;
                finished[head] <= 1'b0;
            end
            if (ret_go[1]) begin
                busy[head_nxt]     <= 1'b0;
                finished[head_nxt] <= 1'b0;
            end
            if (cmp_a.valid) finished[cmp_a.rob_idx] <= 1'b1;
            if (cmp_b.valid) finished[cmp_b.rob_idx] <= 1'b1;
            for (int l = 0; l < `CORE_WIDTH; l++) begin
                if (disp[l].valid) begin    // Allocate at tail
                    busy[disp_idx[l]]     <= 1'b1;
                    finished[disp_idx[l]] <= 1'b0;
                end
            end
            ret[0].valid <= ret_go[0] & ~is_store_q[head];      // Register writes only
            ret[0].rd    <= rd_q[head];
            ret[0].data  <= data_q[head];
            ret[1].valid <= ret_go[1] & ~is_store_q[head_nxt];
            ret[1].rd    <= rd_q[head_nxt];
            ret[1].data  <= data_q[head_nxt];
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < `CORE_WIDTH; l++) begin
            if (disp[l].valid) begin
                is_store_q[disp_idx[l]] <= disp[l].is_store;
                rd_q[disp_idx[l]]       <= disp[l].rd;
            end
        end
        if (cmp_a.valid) begin
            data_q[cmp_a.rob_idx] <= cmp_a.data;
            addr_q[cmp_a.rob_idx] <= cmp_a.addr;
        end
        if (cmp_b.valid) begin
            data_q[cmp_b.rob_idx] <= cmp_b.data;
            addr_q[cmp_b.rob_idx] <= cmp_b.addr;
        end
    end

endmodule

//--- rob_pointers.sv
`timescale 1ns/10ps
`include "core_config.svh"

module rob_pointers (
    input  logic                 clk,
    input  logic                 rst_n,
    input  core_pkg::credit_cnt_t disp_cnt,    // Valid dispatch lanes this cycle
    input  core_pkg::credit_cnt_t ret_cnt,     // Entries retiring this cycle
    output core_pkg::rob_idx_t   head,
    output core_pkg::rob_idx_t   tail,
    output core_pkg::credit_cnt_t credit_ret
);

    // One extra bit so a full ROB (16) is distinct from empty
    localparam int OCC_W = $clog2(`CORE_ROB_DEPTH) + 1;

    logic [OCC_W-1:0] occ;  // Allocated entries, head to tail

    ////////////////////////////////////////////////////////////////////////////
    // Head and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            occ  <= '0;
        end else begin
            head <= head + core_pkg::rob_idx_t'(ret_cnt);               // Oldest entry
            occ  <= occ + OCC_W'(disp_cnt) - OCC_W'(ret_cnt);           // Credits keep it <= 16
        end
    end

    // Tail sits occ entries past head and wraps with the index width
    assign tail = head + core_pkg::rob_idx_t'(occ);

    ////////////////////////////////////////////////////////////////////////////
    // Credit return
    ////////////////////////////////////////////////////////////////////////////

    // Registered so credits line up with the registered ret lanes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_ret <= '0;
        end else begin
            credit_ret <= ret_cnt;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator from vlog.f, run, then search the log for the pass message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/10ps --top-module tb_core_retire \
    -f vlog.f -o tb_core_retire \
    && ./obj_dir/tb_core_retire > sim.log 2>&1 \
    || { echo "Build or run error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- store_buffer.sv
`timescale 1ns/10ps
`include "core_config.svh"

module store_buffer (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  core_pkg::sb_push_t [`CORE_WIDTH-1:0]   sb_push,
    output core_pkg::credit_cnt_t                  sb_free_cnt,
    input  logic                                   drain_pick,     // Offered entry taken
    output core_pkg::store_t                       drain_store,
    output logic                                   drain_avail,
    input  logic                                   store_finish,
    input  core_pkg::word_t                        store_fin_addr
);

    localparam int DEPTH = `CORE_SB_DEPTH;

    core_pkg::store_t sb_mem [DEPTH];
    logic [DEPTH-1:0] busy;     // Holds a retired store
    logic [DEPTH-1:0] sent;     // Already handed to the drain FSM

    core_pkg::sb_idx_t  free0, free1, drain_idx;
    logic               free0_ok, free1_ok;
    core_pkg::sb_push_t push_lo;    // First valid push goes to free0

    ////////////////////////////////////////////////////////////////////////////
    // Free slot scan from the highest index down
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        free0    = '0;
        free0_ok = 1'b0;
        free1    = '0;
        free1_ok = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (!busy[i]) begin         // Last hit wins and gives the top free slot
                free0    = core_pkg::sb_idx_t'(i);
                free0_ok = 1'b1;
            end
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (!busy[i] && (core_pkg::sb_idx_t'(i) != free0)) begin
                free1    = core_pkg::sb_idx_t'(i);  // Next free below free0
                free1_ok = 1'b1;
            end
        end
    end

    assign sb_free_cnt = free1_ok ? 2'd2 : (free0_ok ? 2'd1 : 2'd0);
    assign push_lo     = sb_push[0].valid ? sb_push[0] : sb_push[1];

    // Lowest slot number first among busy and unsent
    always_comb begin
        drain_idx   = '0;
        drain_avail = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (busy[i] && !sent[i]) begin
                drain_idx   = core_pkg::sb_idx_t'(i);
                drain_avail = 1'b1;
            end
        end
    end

    assign drain_store = sb_mem[drain_idx];

    ////////////////////////////////////////////////////////////////////////////
    // Entry state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
            sent <= '0;
        end else begin
            if (drain_pick) sent[drain_idx] <= 1'b1;
            for (int i = 0; i < DEPTH; i++) begin
                if (store_finish && busy[i] && (sb_mem[i].addr == store_fin_addr)) begin
                    busy[i] <= 1'b0;    // Unique addresses give an exact match
                    sent[i] <= 1'b0;
                end
            end
            if (push_lo.valid) begin
                busy[free0] <= 1'b1;
                sent[free0] <= 1'b0;
            end
            if (sb_push[0].valid && sb_push[1].valid) begin
                busy[free1] <= 1'b1;
                sent[free1] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_lo.valid) sb_mem[free0] <= push_lo.st;
        if (sb_push[0].valid && sb_push[1].valid) sb_mem[free1] <= sb_push[1].st;
    end

endmodule

//--- store_drain_fsm.sv
`timescale 1ns/10ps

module store_drain_fsm (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              drain_avail,    // Store buffer has an unsent entry
    input  core_pkg::store_t  drain_store,
    input  logic              store_finish,   // Cache done with the outstanding store
    output logic              drain_pick,
    output logic              st_req_valid,
    output core_pkg::store_t  st_req
);

    core_pkg::drain_state_t state, state_nxt;

    ////////////////////////////////////////////////////////////////////////////
    // One store in flight at the cache
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            core_pkg::IDLE: if (drain_avail) state_nxt = core_pkg::SEND;
            core_pkg::SEND: state_nxt = store_finish ? core_pkg::IDLE  // Zero-delay answer
                                                     : core_pkg::WAIT;
            core_pkg::WAIT: if (store_finish) state_nxt = core_pkg::IDLE;
            default:        state_nxt = core_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= core_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign drain_pick   = (state == core_pkg::IDLE) & drain_avail;   // Marks entry sent
    assign st_req_valid = (state == core_pkg::SEND);                 // Exactly one cycle

    // Request captured at pick and presented in SEND
    always_ff @(posedge clk) begin
        if (drain_pick) st_req <= drain_store;
    end

endmodule

//--- tb_core_retire.sv
`timescale 1ns/10ps
`include "core_config.svh"

module tb_core_retire;

    localparam int N_MIXED     = 300;                // Mixed stream for in-order retire
    localparam int N_BACKPRESS = 48;                 // Store heavy burst against a stalled cache
    localparam int N_DUAL      = 64;                 // Register-only burst for dual retire
    localparam int TOTAL_INSTR = N_MIXED + N_BACKPRESS + N_DUAL;
    localparam int CYCLE_LIMIT = 40 * TOTAL_INSTR + 1000;
    localparam int ROB_DEPTH   = `CORE_ROB_DEPTH;
    localparam int SB_DEPTH    = `CORE_SB_DEPTH;
    localparam core_pkg::word_t ADDR_BASE = 32'h1000_0000;  // Store n uses ADDR_BASE + 4n

    logic                                  clk = 1'b0;
    logic                                  rst_n;
    core_pkg::dispatch_t [`CORE_WIDTH-1:0] disp;
    core_pkg::complete_t                   cmp_a;
    core_pkg::complete_t                   cmp_b;
    logic                                  store_finish;
    core_pkg::word_t                       store_fin_addr;
    core_pkg::retire_t   [`CORE_WIDTH-1:0] ret;
    core_pkg::credit_cnt_t                 credit_ret;
    logic                                  st_req_valid;
    core_pkg::store_t                      st_req;

    // Reference model with one slot per instruction in program order
    logic               m_is_store [TOTAL_INSTR];
    core_pkg::reg_idx_t m_rd       [TOTAL_INSTR];
    core_pkg::word_t    m_data     [TOTAL_INSTR];
    core_pkg::word_t    m_addr     [TOTAL_INSTR];
    logic               m_sent     [TOTAL_INSTR];   // Seen on st_req
    int                 pending [$];                // Dispatched but not yet completed

    integer seed;
    int     disp_seq;       // Next program number
    int     ret_seq;        // Entries retired so far
    int     credits;        // Dispatcher credit counter
    int     credit_sum;
    int     credit_viol;
    int     st_ret_cnt;     // Stores retired
    int     st_fin_cnt;     // Stores finished by the cache
    int     st_req_cnt;
    int     max_out;        // Peak of retired but unfinished stores
    int     dual_cnt;       // Cycles with both ret lanes valid
    int     disp_left;      // Phase knobs
    int     store_pct;
    int     cmp_pct;
    logic   dual_mode;
    logic   hold_cache;     // Cache holds off store_finish
    logic   fin_pending;    // Cache model has one store outstanding
    int     fin_delay;
    core_pkg::word_t fin_addr;
    int     errors;
    int     errors_at_start;
    int     test_no;
    int     tests_passed;
    int     tests_failed;
    int     cycles = 0;

    core_retire_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .disp           (disp),
        .cmp_a          (cmp_a),
        .cmp_b          (cmp_b),
        .store_finish   (store_finish),
        .store_fin_addr (store_fin_addr),
        .ret            (ret),
        .credit_ret     (credit_ret),
        .st_req_valid   (st_req_valid),
        .st_req         (st_req)
    );

    always #5 clk = ~clk;   // 10 ns period

    // Run limit scaled to the instruction count
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checking and reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Error: %s actual 0x%0h expected 0x%0h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic finish_test(input string name);
        test_no++;
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("Test %0d %s: passed", test_no, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", test_no, name,
                     errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    task automatic check_idle_outputs();
        check_value("ret[0].valid", 64'(ret[0].valid), 64'd0);
        check_value("ret[1].valid", 64'(ret[1].valid), 64'd0);
        check_value("credit_ret", 64'(credit_ret), 64'd0);
        check_value("st_req_valid", 64'(st_req_valid), 64'd0);
    endtask

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Output side of the model sampled 1 ns after the edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic observe_outputs();
        int n;
        int s;
        n = int'(credit_ret);
        if (n > disp_seq - ret_seq) begin
            report_problem($sformatf("credit_ret gave back %0d credits with %0d entries in flight",
                                     n, disp_seq - ret_seq));
            n = disp_seq - ret_seq;
        end
        for (int l = 0; l < `CORE_WIDTH; l++) begin
            if (l < n) begin                    // Lane l carries entry ret_seq + l
                s = ret_seq + l;
                check_value($sformatf("ret[%0d].valid", l), 64'(ret[l].valid),
                            64'(!m_is_store[s]));
                if (m_is_store[s]) begin
                    st_ret_cnt++;               // Went to the store buffer instead
                end else begin
                    check_value($sformatf("ret[%0d].rd", l), 64'(ret[l].rd), 64'(m_rd[s]));
                    check_value($sformatf("ret[%0d].data", l), 64'(ret[l].data),
                                64'(m_data[s]));
                end
            end else begin
                check_value($sformatf("ret[%0d].valid", l), 64'(ret[l].valid), 64'd0);
            end
        end
        if (ret[0].valid && ret[1].valid) dual_cnt++;
        ret_seq    += n;
        credits    += int'(credit_ret);         // Model credits follow credit_ret as returned
        credit_sum += int'(credit_ret);
        if (credits > ROB_DEPTH) begin
            credit_viol++;
            $display("Credit count rose to %0d, above the ROB depth", credits);
        end
        if (st_ret_cnt - st_fin_cnt > SB_DEPTH) begin
            report_problem($sformatf("%0d stores retired and unfinished, more than the buffer holds",
                                     st_ret_cnt - st_fin_cnt));
        end
        if (st_ret_cnt - st_fin_cnt > max_out) max_out = st_ret_cnt - st_fin_cnt;

        // Cache side takes the request in its valid cycle
        if (st_req_valid) begin
            s = int'((st_req.addr - ADDR_BASE) >> 2);
            if (st_req.addr < ADDR_BASE || st_req.addr[1:0] != 2'b00 || s >= disp_seq
                || !m_is_store[s]) begin
                report_problem($sformatf("st_req names address 0x%0h of no dispatched store",
                                         st_req.addr));
            end else begin
                if (s >= ret_seq) begin
                    report_problem($sformatf("Store %0d reached the cache before it retired", s));
                end
                if (m_sent[s]) begin
                    report_problem($sformatf("Store to 0x%0h reached the cache twice", st_req.addr));
                end
                check_value("st_req.data", 64'(st_req.data), 64'(m_data[s]));
                m_sent[s] = 1'b1;
            end
            if (fin_pending) report_problem("A second store request came while one was open");
            st_req_cnt++;
            fin_pending = 1'b1;
            fin_addr    = st_req.addr;
            fin_delay   = rnd(21);              // Answer after 0 to 20 cycles
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Input side of the model driven 1 ns after the edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic pop_random_completion(output core_pkg::complete_t c);
        int k;
        int seq;
        k   = rnd(pending.size());
        seq = pending[k];
        pending.delete(k);
        c.valid   = 1'b1;
        c.rob_idx = core_pkg::rob_idx_t'(seq % ROB_DEPTH);
        c.data    = m_data[seq];
        c.addr    = m_is_store[seq] ? m_addr[seq] : '0;
    endtask

    task automatic drive_inputs();
        int n;
        int seq;
        cmp_a = '0;
        cmp_b = '0;
        // Completions only name entries dispatched in earlier cycles
        if (pending.size() > 0 && rnd(100) < cmp_pct) pop_random_completion(cmp_a);
        if (pending.size() > 0 && rnd(100) < cmp_pct) pop_random_completion(cmp_b);

        disp = '0;
        n = dual_mode ? 2 : rnd(3);
        if (n > credits) n = credits;           // Never dispatch without credit
        if (n > disp_left) n = disp_left;
        for (int l = 0; l < n; l++) begin
            seq = disp_seq;
            m_is_store[seq] = (rnd(100) < store_pct);
            m_rd[seq]       = core_pkg::reg_idx_t'(rnd(32));
            m_data[seq]     = core_pkg::word_t'($random(seed));
            m_addr[seq]     = ADDR_BASE + core_pkg::word_t'(seq * 4);   // Unique per store
            m_sent[seq]     = 1'b0;
            disp[l].valid    = 1'b1;
            disp[l].is_store = m_is_store[seq];
            disp[l].rd       = m_rd[seq];
            pending.push_back(seq);
            disp_seq++;
        end
        credits   -= n;
        disp_left -= n;

        store_finish   = 1'b0;
        store_fin_addr = '0;
        if (fin_pending && !hold_cache) begin
            if (fin_delay == 0) begin
                store_finish   = 1'b1;
                store_fin_addr = fin_addr;
                fin_pending    = 1'b0;
                st_fin_cnt++;
            end else begin
                fin_delay--;
            end
        end
    endtask

    function automatic logic phase_drained();
        return disp_left == 0 && ret_seq == disp_seq && pending.size() == 0
               && !fin_pending && st_fin_cnt == st_ret_cnt;
    endfunction

    // Runs until everything dispatched has retired and every store finished
    task automatic run_phase(input int n_instr, input int st_pct, input int c_pct,
                             input int hold_cycles, input logic dual);
        int   cyc;
        logic done;
        cyc       = 0;
        done      = 1'b0;
        disp_left = n_instr;
        store_pct = st_pct;
        cmp_pct   = c_pct;
        dual_mode = dual;
        while (!done) begin
            @(posedge clk);
            #1;
            observe_outputs();
            done = phase_drained();
            if (!done) begin
                hold_cache = (cyc < hold_cycles);
                drive_inputs();
                cyc++;
            end
        end
        hold_cache   = 1'b0;
        disp         = '0;
        cmp_a        = '0;
        cmp_b        = '0;
        store_finish = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int unsent;
        seed            = 61;
        rst_n           = 1'b0;
        disp            = '0;
        cmp_a           = '0;
        cmp_b           = '0;
        store_finish    = 1'b0;
        store_fin_addr  = '0;
        disp_seq        = 0;
        ret_seq         = 0;
        credits         = ROB_DEPTH;
        credit_sum      = 0;
        credit_viol     = 0;
        st_ret_cnt      = 0;
        st_fin_cnt      = 0;
        st_req_cnt      = 0;
        max_out         = 0;
        dual_cnt        = 0;
        disp_left       = 0;
        store_pct       = 0;
        cmp_pct         = 0;
        dual_mode       = 1'b0;
        hold_cache      = 1'b0;
        fin_pending     = 1'b0;
        fin_delay       = 0;
        fin_addr        = '0;
        errors          = 0;
        errors_at_start = 0;
        test_no         = 0;
        tests_passed    = 0;
        tests_failed    = 0;

        repeat (5) begin                        // Reset held for 5 cycles
            @(posedge clk);
            #1;
            check_idle_outputs();
        end
        rst_n = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #1;
            check_idle_outputs();
        end
        finish_test("reset state");

        run_phase(N_MIXED, 30, 40, 0, 1'b0);    // Random order completions against a random cache
        finish_test("in-order retire");

        check_value("credit_ret total", 64'(credit_sum), 64'(disp_seq));
        check_value("credits after drain", 64'(credits), 64'(ROB_DEPTH));
        check_value("credit overflow cycles", 64'(credit_viol), 64'd0);
        finish_test("credit flow");

        unsent = 0;
        for (int s = 0; s < disp_seq; s++) begin
            if (m_is_store[s] && !m_sent[s]) unsent++;
        end
        check_value("stores never sent", 64'(unsent), 64'd0);
        check_value("st_req count", 64'(st_req_cnt), 64'(st_ret_cnt));
        finish_test("store drain");

        max_out = 0;
        run_phase(N_BACKPRESS, 75, 60, 150, 1'b0);  // Cache silent for 150 cycles
        check_value("peak stores held", 64'(max_out), 64'(SB_DEPTH));
        finish_test("store back-pressure");

        dual_cnt = 0;
        run_phase(N_DUAL, 0, 100, 0, 1'b1);     // Both ports complete every cycle
        check_value("dual retire seen", 64'(dual_cnt != 0), 64'd1);
        check_value("credits after drain", 64'(credits), 64'(ROB_DEPTH));
        finish_test("dual retire");

        $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
core_pkg.sv
rob_pointers.sv
rob_entries.sv
store_buffer.sv
store_drain_fsm.sv
core_retire_top.sv
tb_core_retire.sv
